// File: all.f
+incdir+include
rtl/cache_pkg.sv
rtl/way_ram.sv
rtl/tag_lookup.sv
rtl/cache_ctrl_fsm.sv
rtl/l2_cache_top.sv
testbench/cache_checker.sv
testbench/tb_l2_cache.sv

// File: Bender.yml
package:
  name: l2_cache

export_include_dirs:
  - include

sources:
  - rtl/cache_pkg.sv
  - rtl/way_ram.sv
  - rtl/tag_lookup.sv
  - rtl/cache_ctrl_fsm.sv
  - rtl/l2_cache_top.sv
  - target: test
    files:
      - testbench/cache_checker.sv
      - testbench/tb_l2_cache.sv

// File: testbench/tb_l2_cache.sv
`timescale 1ns/10ps

`include "cache_defs_defs.svh"

module tb_l2_cache;

    localparam int CLK_PERIOD = 4;
    localparam int N_REQUESTS = 240;
    // A write-back and a read of up to 6 cycles each, plus install and hit cycles
    localparam int WORST_MISS = 16;
    localparam int TIMEOUT_NS = (N_REQUESTS * WORST_MISS + 100) * CLK_PERIOD;

    typedef logic [`CACHE_DATA_WIDTH-1:0] word_t;

    logic  clk, rst_n, load, store, mem_ready;
    logic  hit, miss, busy, mem_read, mem_write;
    word_t address, data_in, mem_data;
    word_t mem_address, data_out, mem_write_data;
    word_t mem_store [word_t];
    int    check_errors;
    int    tb_errors;
    int    tests_run;
    int    tests_failed;
    int    mark;

    l2_cache_top dut0 (
        .clk, .rst_n, .load, .store, .address, .data_in, .mem_data, .mem_ready,
        .hit, .miss, .busy, .mem_read, .mem_write, .mem_address, .data_out, .mem_write_data
    );

    cache_checker checker0 (
        .clk, .load, .store, .address, .data_in, .hit, .miss, .busy, .data_out,
        .mem_read, .mem_write, .mem_ready, .mem_address, .mem_write_data,
        .errors (check_errors)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic word_t initial_word(input word_t addr);
        return (addr * 32'h9e37_79b9) ^ 32'h5a5a_a5a5;
    endfunction

    function automatic word_t make_addr(input int tag, input int set);
        return {tag[`CACHE_TAG_WIDTH-1:0], set[`CACHE_SET_WIDTH-1:0], 2'b00};
    endfunction

    // Backing memory answers each strobe after 1 to 5 cycles
    initial begin : backing_memory
        int unsigned delay;
        mem_ready = 1'b0;
        mem_data  = '0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_ready) begin
                mem_ready = 1'b0;
            end else if (mem_read === 1'b1 || mem_write === 1'b1) begin
                delay = $urandom_range(5, 1);
                #((delay - 1) * CLK_PERIOD);
                if (mem_write) begin
                    mem_store[mem_address] = mem_write_data;
                end else begin
                    mem_data = mem_store.exists(mem_address) ? mem_store[mem_address]
                                                            : initial_word(mem_address);
                end
                mem_ready = 1'b1;
            end
        end
    end

    task automatic issue_request(input logic is_store, input word_t addr, input word_t data);
        load    = !is_store;
        store   = is_store;
        address = addr;
        data_in = data;
        do begin
            @(negedge clk);
        end while (!(hit && !busy));
        @(posedge clk);
        #1;
        load  = 1'b0;
        store = 1'b0;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (tb_errors + check_errors != mark) begin
            tests_failed++;
            $display("Test %0d, %s: failed", tests_run, name);
        end else begin
            $display("Test %0d, %s: ok", tests_run, name);
        end
        mark = tb_errors + check_errors;
    endtask

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : stimulus
        void'($urandom(75));
        rst_n        = 1'b0;
        load         = 1'b0;
        store        = 1'b0;
        address      = '0;
        data_in      = '0;
        tb_errors    = 0;
        tests_run    = 0;
        tests_failed = 0;
        mark         = 0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        if (busy !== 1'b0 || mem_read !== 1'b0 || mem_write !== 1'b0) begin
            $display("Error at %0t ns: busy or a memory strobe is not low after reset", $time);
            tb_errors++;
        end
        issue_request(1'b0, make_addr(1, 3), '0);
        finish_test("reset state and first load miss");

        issue_request(1'b1, make_addr(2, 4), 32'hcafe_0001);
        issue_request(1'b0, make_addr(2, 4), '0);
        finish_test("store then load hit");

        // Tag 11 is least recently used when tag 12 arrives
        issue_request(1'b0, make_addr(10, 5), '0);
        issue_request(1'b0, make_addr(11, 5), '0);
        issue_request(1'b0, make_addr(10, 5), '0);
        issue_request(1'b0, make_addr(12, 5), '0);
        issue_request(1'b0, make_addr(10, 5), '0);
        issue_request(1'b0, make_addr(11, 5), '0);
        finish_test("LRU eviction");

        issue_request(1'b1, make_addr(20, 6), 32'h1111_2020);
        issue_request(1'b1, make_addr(21, 6), 32'h2222_2121);
        issue_request(1'b0, make_addr(22, 6), '0);
        issue_request(1'b0, make_addr(20, 6), '0);
        finish_test("dirty write-back and reload");

        issue_request(1'b1, make_addr(30, 7), 32'h3333_3030);
        issue_request(1'b0, make_addr(30, 7), '0);
        issue_request(1'b0, make_addr(31, 7), '0);
        issue_request(1'b0, make_addr(32, 7), '0);
        finish_test("clean store miss installs dirty");

        for (int i = 0; i < 200; i++) begin
            issue_request($urandom_range(1, 0),
                          make_addr($urandom_range(43, 40), $urandom_range(3, 0)), $urandom);
        end
        finish_test("random loads and stores");

        $display("Tests run %0d, failed %0d, errors %0d",
                 tests_run, tests_failed, tb_errors + check_errors);
        if (tests_failed == 0 && tb_errors + check_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/cache_checker.sv
`timescale 1ns/10ps

`include "cache_defs_defs.svh"

module cache_checker (
    input  logic                         clk,
    input  logic                         load,
    input  logic                         store,
    input  logic [`CACHE_DATA_WIDTH-1:0] address,
    input  logic [`CACHE_DATA_WIDTH-1:0] data_in,
    input  logic                         hit,
    input  logic                         miss,
    input  logic                         busy,
    input  logic [`CACHE_DATA_WIDTH-1:0] data_out,
    input  logic                         mem_read,
    input  logic                         mem_write,
    input  logic                         mem_ready,
    input  logic [`CACHE_DATA_WIDTH-1:0] mem_address,
    input  logic [`CACHE_DATA_WIDTH-1:0] mem_write_data,
    output int                           errors
);

    typedef logic [`CACHE_DATA_WIDTH-1:0] word_t;

    // Architectural value of every word that was ever stored
    word_t                       shadow [word_t];
    logic [`CACHE_TAG_WIDTH-1:0] tags  [`CACHE_SETS][2];
    logic                        valid [`CACHE_SETS][2];
    logic                        dirty [`CACHE_SETS][2];
    logic                        lru   [`CACHE_SETS];
    int                          reads_seen;
    int                          writes_seen;

    function automatic word_t initial_word(input word_t addr);
        return (addr * 32'h9e37_79b9) ^ 32'h5a5a_a5a5;
    endfunction

    function automatic word_t expected_word(input word_t addr);
        return shadow.exists(addr) ? shadow[addr] : initial_word(addr);
    endfunction

    // Way holding the address, or -1 when the model predicts a miss
    function automatic int find_way(input word_t addr);
        int s;
        s = addr[`CACHE_SET_WIDTH+1:2];
        for (int w = 0; w < 2; w++) begin
            if (valid[s][w] && tags[s][w] == addr[`CACHE_DATA_WIDTH-1 -: `CACHE_TAG_WIDTH]) begin
                return w;
            end
        end
        return -1;
    endfunction

    // Expected eviction: first empty way, else the way the LRU bit names
    function automatic int victim_of(input word_t addr);
        int s;
        s = addr[`CACHE_SET_WIDTH+1:2];
        return !valid[s][0] ? 0 : (!valid[s][1] ? 1 : int'(lru[s]));
    endfunction

    task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
        $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        errors++;
    endtask

    initial begin : compare
        int    req_set;
        int    way;
        int    victim;
        int    exp_reads;
        int    exp_writes;
        logic  victim_dirty;
        logic  in_miss;
        logic  exp_hit;
        word_t vaddr;
        errors      = 0;
        reads_seen  = 0;
        writes_seen = 0;
        in_miss     = 1'b0;
        for (int s = 0; s < `CACHE_SETS; s++) begin
            lru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                valid[s][w] = 1'b0;
                dirty[s][w] = 1'b0;
                tags[s][w]  = '0;
            end
        end
        forever begin
            @(negedge clk);
            req_set      = address[`CACHE_SET_WIDTH+1:2];
            way          = find_way(address);
            victim       = victim_of(address);
            victim_dirty = valid[req_set][victim] && dirty[req_set][victim];
            vaddr        = {tags[req_set][victim], req_set[`CACHE_SET_WIDTH-1:0], 2'b00};
            if (mem_ready && mem_write) begin
                writes_seen++;
                if (mem_address !== vaddr) begin
                    report_mismatch("mem_address", vaddr, mem_address);
                end
                if (mem_write_data !== expected_word(vaddr)) begin
                    report_mismatch("mem_write_data", expected_word(vaddr), mem_write_data);
                end
            end
            if (mem_ready && mem_read) begin
                reads_seen++;
                if (mem_address !== address) begin
                    report_mismatch("mem_address", address, mem_address);
                end
                if (way < 0 && victim_dirty && writes_seen == 0) begin
                    $display(
                        "Error at %0t ns: memory read came before the write-back of victim %h",
                        $time, vaddr);
                    errors++;
                end
            end
            // The tags only change when the miss ends, so a serviced miss hits once busy falls
            if (load || store) begin
                if (busy) begin
                    in_miss = 1'b1;
                    exp_hit = 1'b0;
                end else begin
                    exp_hit = in_miss || (way >= 0);
                end
                if (hit !== exp_hit) begin
                    report_mismatch("hit", word_t'(exp_hit), word_t'(hit));
                end
                if (miss !== !exp_hit) begin
                    report_mismatch("miss", word_t'(!exp_hit), word_t'(miss));
                end
            end
            if ((load || store) && hit && !busy) begin
                exp_writes = (way < 0 && victim_dirty) ? 1 : 0;
                exp_reads  = (way < 0 && load) ? 1 : 0;
                if (load && data_out !== expected_word(address)) begin
                    report_mismatch("data_out", expected_word(address), data_out);
                end
                if (reads_seen != exp_reads || writes_seen != exp_writes) begin
                    $display(
                        "Error at %0t ns: %h took %0d reads and %0d writes, expected %0d and %0d",
                        $time, address, reads_seen, writes_seen, exp_reads, exp_writes);
                    errors++;
                end
                if (way < 0) begin
                    way                  = victim;
                    tags[req_set][way]  = address[`CACHE_DATA_WIDTH-1 -: `CACHE_TAG_WIDTH];
                    valid[req_set][way] = 1'b1;
                    dirty[req_set][way] = 1'b0;
                end
                if (store) begin
                    dirty[req_set][way] = 1'b1;
                    shadow[address]     = data_in;
                end
                lru[req_set] = (way == 0);
                reads_seen   = 0;
                writes_seen  = 0;
                in_miss      = 1'b0;
            end
        end
    end

endmodule

// File: rtl/l2_cache_top.sv
`timescale 1ns/10ps

`include "cache_defs_defs.svh"

module l2_cache_top
    import cache_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         load,
    input  logic                         store,
    input  logic [`CACHE_DATA_WIDTH-1:0] address,
    input  logic [`CACHE_DATA_WIDTH-1:0] data_in,
    input  logic [`CACHE_DATA_WIDTH-1:0] mem_data,
    input  logic                         mem_ready,
    output logic                         hit,
    output logic                         miss,
    output logic                         busy,
    output logic                         mem_read,
    output logic                         mem_write,
    output logic [`CACHE_DATA_WIDTH-1:0] mem_address,
    output logic [`CACHE_DATA_WIDTH-1:0] data_out,
    output logic [`CACHE_DATA_WIDTH-1:0] mem_write_data
);

    typedef logic [`CACHE_DATA_WIDTH-1:0] word_t;

    cache_req_t req;
    lookup_t    look;
    tag_entry_t entry0, entry1, new_entry;
    word_t      data0, data1, new_data;
    logic [1:0] tag_we, data_we;
    logic       lru_update, lru_way;

    assign req = '{load: load, store: store, address: address, data_in: data_in};

    assign hit            = look.hit;
    assign miss           = !look.hit && (load || store);
    assign data_out       = look.hit_way ? data1 : data0;
    assign mem_write_data = look.victim_way ? data1 : data0;

    cache_ctrl_fsm u_ctrl (
        .clk, .rst_n, .req, .look, .mem_data, .mem_ready,
        .busy, .mem_read, .mem_write, .mem_address,
        .tag_we, .data_we, .new_entry, .new_data, .lru_update, .lru_way
    );

    tag_lookup u_lookup (
        .clk, .rst_n, .req, .entry0, .entry1, .lru_update, .lru_way,
        .result (look)
    );

    way_ram #(.payload_t(tag_entry_t)) u_tags (
        .clk, .rst_n,
        .index  (address[`CACHE_SET_WIDTH+1:2]),
        .we     (tag_we),
        .wdata  (new_entry),
        .rdata0 (entry0),
        .rdata1 (entry1)
    );

    way_ram #(.payload_t(word_t)) u_data (
        .clk, .rst_n,
        .index  (address[`CACHE_SET_WIDTH+1:2]),
        .we     (data_we),
        .wdata  (new_data),
        .rdata0 (data0),
        .rdata1 (data1)
    );

endmodule

// File: rtl/cache_ctrl_fsm.sv
`timescale 1ns/10ps

`include "cache_defs_defs.svh"

module cache_ctrl_fsm
    import cache_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  cache_req_t                   req,
    input  lookup_t                      look,
    input  logic [`CACHE_DATA_WIDTH-1:0] mem_data,
    input  logic                         mem_ready,
    output logic                         busy,
    output logic                         mem_read,
    output logic                         mem_write,
    output logic [`CACHE_DATA_WIDTH-1:0] mem_address,
    output logic [1:0]                   tag_we,
    output logic [1:0]                   data_we,
    output tag_entry_t                   new_entry,
    output logic [`CACHE_DATA_WIDTH-1:0] new_data,
    output logic                         lru_update,
    output logic                         lru_way
);

    ctrl_state_t                  state;
    logic [`CACHE_DATA_WIDTH-1:0] fill_q;
    logic                         access;
    logic                         miss;
    logic                         store_hit;
    logic [`CACHE_SET_WIDTH-1:0]  index;
    logic [1:0]                   install_we;

    assign access    = req.load || req.store;
    assign miss      = access && !look.hit;
    assign store_hit = (state == IDLE) && look.hit && req.store;
    assign index     = req.address[`CACHE_SET_WIDTH+1:2];

    // Write-back targets the victim line, every other access the request address
    assign mem_address = (state == WRITE_BACK) ? {look.victim_tag, index, 2'b00}
                                               : req.address;

    assign install_we = look.victim_way ? 2'b10 : 2'b01;

    always_comb begin
        tag_we  = 2'b00;
        data_we = 2'b00;
        if (store_hit) begin
            tag_we  = look.hit_way ? 2'b10 : 2'b01;
            data_we = look.hit_way ? 2'b10 : 2'b01;
        end else if (state == UPDATE) begin
            tag_we  = install_we;
            data_we = install_we;
        end
    end

    // A store hit always leaves the line dirty, an install only when it was a store
    assign new_entry.valid = 1'b1;
    assign new_entry.dirty = req.store;
    assign new_entry.tag   = req.address[`CACHE_DATA_WIDTH-1 -: `CACHE_TAG_WIDTH];
    assign new_data        = req.store ? req.data_in : fill_q;

    assign lru_update = ((state == IDLE) && look.hit && access) || (state == UPDATE);
    assign lru_way    = (state == UPDATE) ? look.victim_way : look.hit_way;

    always_ff @(posedge clk) begin
        if (state == READ_MISS && mem_ready) begin
            fill_q <= mem_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            busy      <= 1'b0;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (miss) begin
                        busy <= 1'b1;
                        if (look.victim_dirty) begin
                            mem_write <= 1'b1;
                            state     <= WRITE_BACK;
                        end else if (req.load) begin
                            mem_read <= 1'b1;
                            state    <= READ_MISS;
                        end else begin
                            state <= WRITE_MISS;
                        end
                    end
                end
                WRITE_BACK: begin
                    if (mem_ready) begin
                        mem_write <= 1'b0;
                        mem_read  <= req.load;
                        state     <= req.load ? READ_MISS : WRITE_MISS;
                    end
                end
                READ_MISS: begin
                    if (mem_ready) begin
                        mem_read <= 1'b0;
                        state    <= UPDATE;
                    end
                end
                WRITE_MISS: begin
                    state <= UPDATE;
                end
                UPDATE: begin
                    busy  <= 1'b0;
                    state <= IDLE;
                end
                default: begin
                    busy      <= 1'b0;
                    mem_read  <= 1'b0;
                    mem_write <= 1'b0;
                    state     <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: rtl/tag_lookup.sv
`timescale 1ns/10ps

`include "cache_defs_defs.svh"

module tag_lookup
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  cache_req_t req,
    input  tag_entry_t entry0,
    input  tag_entry_t entry1,
    input  logic       lru_update,
    input  logic       lru_way,
    output lookup_t    result
);

    logic [`CACHE_TAG_WIDTH-1:0] tag;
    logic [`CACHE_SET_WIDTH-1:0] index;
    logic [`CACHE_SETS-1:0]      lru;
    logic                        match0;
    logic                        match1;
    logic                        victim;

    assign tag   = req.address[`CACHE_DATA_WIDTH-1 -: `CACHE_TAG_WIDTH];
    assign index = req.address[`CACHE_SET_WIDTH+1:2];

    assign match0 = entry0.valid && (entry0.tag == tag);
    assign match1 = entry1.valid && (entry1.tag == tag);

    // An empty way is filled before anything is evicted
    always_comb begin
        if (!entry0.valid) begin
            victim = 1'b0;
        end else if (!entry1.valid) begin
            victim = 1'b1;
        end else begin
            victim = lru[index];
        end
    end

    always_comb begin
        result.hit        = match0 || match1;
        result.hit_way    = !match0 && match1;
        result.victim_way = victim;
        if (victim) begin
            result.victim_dirty = entry1.valid && entry1.dirty;
            result.victim_tag   = entry1.tag;
        end else begin
            result.victim_dirty = entry0.valid && entry0.dirty;
            result.victim_tag   = entry0.tag;
        end
    end

    // The LRU bit names the way to evict next, so it points away from the way just used
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru <= '0;
        end else if (lru_update) begin
            lru[index] <= !lru_way;
        end
    end

endmodule

// File: rtl/way_ram.sv
`timescale 1ns/10ps

`include "cache_defs_defs.svh"

module way_ram #(
    parameter type payload_t = logic [`CACHE_DATA_WIDTH-1:0]
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`CACHE_SET_WIDTH-1:0] index,
    input  logic [1:0]                  we,
    input  payload_t                    wdata,
    output payload_t                    rdata0,
    output payload_t                    rdata1
);

    payload_t way0 [`CACHE_SETS];
    payload_t way1 [`CACHE_SETS];

    // Both ways of the set are visible in the request cycle
    assign rdata0 = way0[index];
    assign rdata1 = way1[index];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CACHE_SETS; i++) begin
                way0[i] <= '0;
                way1[i] <= '0;
            end
        end else begin
            if (we[0]) begin
                way0[index] <= wdata;
            end
            if (we[1]) begin
                way1[index] <= wdata;
            end
        end
    end

endmodule

// File: rtl/cache_pkg.sv
`include "cache_defs_defs.svh"

package cache_pkg;

    // One tag entry per way
    typedef struct packed {
        logic                        valid;
        logic                        dirty;
        logic [`CACHE_TAG_WIDTH-1:0] tag;
    } tag_entry_t;

    // Request as seen from the requester ports
    typedef struct packed {
        logic                         load;
        logic                         store;
        logic [`CACHE_DATA_WIDTH-1:0] address;
        logic [`CACHE_DATA_WIDTH-1:0] data_in;
    } cache_req_t;

    // Result of comparing the request with the indexed set
    typedef struct packed {
        logic                        hit;
        logic                        hit_way;
        logic                        victim_way;
        logic                        victim_dirty;
        logic [`CACHE_TAG_WIDTH-1:0] victim_tag;
    } lookup_t;

    typedef enum logic [2:0] {
        IDLE,
        WRITE_BACK,
        READ_MISS,
        WRITE_MISS,
        UPDATE
    } ctrl_state_t;

endpackage

// File: include/cache_defs_defs.svh
`ifndef CACHE_DEFS_DEFS_SVH
`define CACHE_DEFS_DEFS_SVH

// Word width, also used as the address width
`define CACHE_DATA_WIDTH 32

// Number of index bits selecting a set
`define CACHE_SET_WIDTH 6

// Address bits above the index and the byte offset
`define CACHE_TAG_WIDTH (`CACHE_DATA_WIDTH - `CACHE_SET_WIDTH - 2)

// Sets in the array
`define CACHE_SETS (1 << `CACHE_SET_WIDTH)

`endif
